// File: verilog/ccm_pkg.sv
package ccm_pkg;

    // pixel, weight, bias and result word
    localparam int DATA_W = 16;

    // external pixel memory
    localparam int ADDR_W = 20;

    // configuration fields
    localparam int DIM_W   = 9;   // width, height
    localparam int CHN_W   = 10;  // input channels, kernels
    localparam int KSIZE_W = 3;   // filter side

    // word address inside one lane's kernel buffer
    localparam int KADDR_W = 12;

    // even row high, odd row low
    localparam int LANE_OUT_W = 2 * DATA_W;

endpackage

// File: verilog/kernel_loader.sv
`timescale 1ns/1ps

module kernel_loader import ccm_pkg::*; #(
    parameter int NUM_LANES  = 16,
    parameter int KERN_DEPTH = 4096
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 kern_load_start,
    input  logic                 kern_vld,
    input  logic [CHN_W-1:0]     cfg_num_fmap,
    input  logic [KSIZE_W-1:0]   cfg_kern_size,
    output logic [NUM_LANES-1:0] kern_wr_lane,
    output logic [KADDR_W-1:0]   kern_wr_addr
);

    localparam int LW_W = CHN_W + 2 * KSIZE_W + 1;

    logic [LW_W-1:0] lane_words;
    logic            last_word;

    // bias word plus channels x K x K weights
    assign lane_words = LW_W'(cfg_num_fmap) * LW_W'(cfg_kern_size) * LW_W'(cfg_kern_size)
                      + LW_W'(1);
    assign last_word  = (LW_W'(kern_wr_addr) + LW_W'(1) == lane_words);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kern_wr_lane <= NUM_LANES'(1);
            kern_wr_addr <= '0;
        end else if (kern_load_start) begin
            kern_wr_lane <= NUM_LANES'(1);  // restart at lane 0
            kern_wr_addr <= '0;
        end else if (kern_vld) begin
            if (last_word) begin
                kern_wr_lane <= {kern_wr_lane[NUM_LANES-2:0], kern_wr_lane[NUM_LANES-1]};
                kern_wr_addr <= '0;
            end else begin
                kern_wr_addr <= kern_wr_addr + KADDR_W'(1);
            end
        end
    end

    // a kernel too large for the lane buffer would wrap over the bias
    a_kern_addr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        kern_vld |-> (lane_words <= KERN_DEPTH)
    ) else $error("kernel of %0d words beyond buffer", lane_words);

endmodule

// File: verilog/conv_sequencer.sv
`timescale 1ns/1ps

module conv_sequencer import ccm_pkg::*; #(
    parameter int KERN_DEPTH = 4096
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               op_start,
    input  logic               kern_load_start,
    input  logic               kern_load_work,
    input  logic               px_rd_vld,
    input  logic               take_rdy,
    input  logic [ADDR_W-1:0]  row0_addr,
    input  logic [DIM_W-1:0]   cfg_width,
    input  logic [DIM_W-1:0]   cfg_height,
    input  logic [CHN_W-1:0]   cfg_num_fmap,
    input  logic [CHN_W-1:0]   cfg_num_kernel,
    input  logic [KSIZE_W-1:0] cfg_kern_size,
    output logic               busy,
    output logic               px_rd_req,
    output logic [ADDR_W-1:0]  px_rd_addr,
    output logic               mac_step,
    output logic [KADDR_W-1:0] weight_addr,
    output logic               row_sel,
    output logic               acc_init,
    output logic               take_vld
);

    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOAD    = 3'd1;
    localparam logic [2:0] ST_SETUP   = 3'd2;
    localparam logic [2:0] ST_BIAS    = 3'd3;
    localparam logic [2:0] ST_FETCH   = 3'd4;
    localparam logic [2:0] ST_ADVANCE = 3'd5;
    localparam logic [2:0] ST_ENC     = 3'd6;

    logic [2:0]         state;
    logic [2:0]         state_nxt;

    logic [CHN_W-1:0]   chn;
    logic [KSIZE_W-1:0] fc;
    logic [KSIZE_W-1:0] fr;
    logic [DIM_W-1:0]   out_row;
    logic [DIM_W-1:0]   out_col;
    logic               row_odd;

    logic               chn_last;
    logic               fc_last;
    logic               fr_last;
    logic               row_last;
    logic               col_last;
    logic               row_done;

    logic [ADDR_W-1:0]  plane_sz;
    logic [ADDR_W-1:0]  chan_off;
    logic [ADDR_W-1:0]  row_off;
    logic [ADDR_W-1:0]  col_off;
    logic [KADDR_W-1:0] ksq;

    assign chn_last = (chn + CHN_W'(1) == cfg_num_fmap);
    assign fc_last  = (fc + KSIZE_W'(1) == cfg_kern_size);
    assign fr_last  = (fr + KSIZE_W'(1) == cfg_kern_size);
    // last output position: index + K reaches the input size
    assign row_last = (out_row + DIM_W'(cfg_kern_size) == cfg_height);
    assign col_last = (out_col + DIM_W'(cfg_kern_size) == cfg_width);
    assign row_done = chn_last && fc_last && fr_last;

    // row0 + chn*H*W + (r+fr)*W + (c+fc)
    assign plane_sz   = ADDR_W'(cfg_height) * ADDR_W'(cfg_width);
    assign chan_off   = ADDR_W'(chn) * plane_sz;
    assign row_off    = (ADDR_W'(out_row) + ADDR_W'(fr)) * ADDR_W'(cfg_width);
    assign col_off    = ADDR_W'(out_col) + ADDR_W'(fc);
    assign px_rd_addr = row0_addr + chan_off + row_off + col_off;

    // word 0 holds the bias
    assign ksq         = KADDR_W'(cfg_kern_size) * KADDR_W'(cfg_kern_size);
    assign weight_addr = KADDR_W'(1) + KADDR_W'(chn) * ksq
                       + KADDR_W'(fr) * KADDR_W'(cfg_kern_size) + KADDR_W'(fc);

    assign busy      = (state != ST_IDLE);
    assign px_rd_req = (state == ST_FETCH);
    assign mac_step  = (state == ST_FETCH);
    assign acc_init  = (state == ST_BIAS);
    assign take_vld  = (state == ST_ENC);
    assign row_sel   = row_odd;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (kern_load_start)
                    state_nxt = ST_LOAD;
                else if (op_start && cfg_num_kernel != '0)  // nothing to do without kernels
                    state_nxt = ST_SETUP;
            end
            ST_LOAD: begin
                if (!kern_load_work)
                    state_nxt = ST_IDLE;
            end
            ST_SETUP:  state_nxt = ST_BIAS;
            ST_BIAS:   state_nxt = ST_FETCH;
            ST_FETCH: begin
                if (px_rd_vld)
                    state_nxt = ST_ADVANCE;
            end
            ST_ADVANCE: begin
                if (row_done && (row_odd || row_last))
                    state_nxt = ST_ENC;  // row pair complete
                else
                    state_nxt = ST_FETCH;
            end
            ST_ENC: begin
                if (take_rdy)
                    state_nxt = (row_last && col_last) ? ST_IDLE : ST_BIAS;
            end
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            chn     <= '0;
            fc      <= '0;
            fr      <= '0;
            out_row <= '0;
            out_col <= '0;
            row_odd <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                ST_SETUP: begin
                    chn     <= '0;
                    fc      <= '0;
                    fr      <= '0;
                    out_row <= '0;
                    out_col <= '0;
                    row_odd <= 1'b0;
                end
                ST_ADVANCE: begin
                    if (!chn_last) begin
                        chn <= chn + CHN_W'(1);
                    end else begin
                        chn <= '0;
                        if (!fc_last) begin
                            fc <= fc + KSIZE_W'(1);
                        end else begin
                            fc <= '0;
                            if (!fr_last) begin
                                fr <= fr + KSIZE_W'(1);
                            end else begin
                                fr <= '0;
                                if (!row_odd && !row_last) begin  // on to the odd row
                                    row_odd <= 1'b1;
                                    out_row <= out_row + DIM_W'(1);
                                end
                            end
                        end
                    end
                end
                ST_ENC: begin
                    if (take_rdy) begin
                        row_odd <= 1'b0;
                        if (row_last) begin
                            out_row <= '0;
                            out_col <= out_col + DIM_W'(1);
                        end else begin
                            out_row <= out_row + DIM_W'(1);
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // a stalled handoff waits for the encoder
    a_take_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        take_vld && !take_rdy |=> take_vld
    ) else $error("take_vld dropped before take_rdy");

    // results are frozen for the encoder, so no new pixel may arrive
    a_no_req_in_take: assert property (
        @(posedge clk) disable iff (!rst_n)
        take_vld |=> !px_rd_req
    ) else $error("pixel request during encoder handoff");

    // all channel weights sit behind the bias word
    a_weight_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        px_rd_req |-> (ADDR_W'(cfg_num_fmap) * ADDR_W'(ksq) < KERN_DEPTH)
    ) else $error("%0d channels of weights beyond kernel buffer", cfg_num_fmap);

endmodule

// File: verilog/mac_lane.sv
`timescale 1ns/1ps

module mac_lane import ccm_pkg::*; #(
    parameter int KERN_DEPTH = 4096
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lane_en,
    input  logic                  kern_we,
    input  logic [KADDR_W-1:0]    kern_wr_addr,
    input  logic [DATA_W-1:0]     kern_data,
    input  logic                  step,
    input  logic [DATA_W-1:0]     px_data,
    input  logic [KADDR_W-1:0]    weight_addr,
    input  logic                  row_sel,
    input  logic                  acc_init,
    output logic [LANE_OUT_W-1:0] lane_out
);

    logic [DATA_W-1:0] kern_mem [KERN_DEPTH];
    logic [DATA_W-1:0] bias;
    logic [DATA_W-1:0] weight;
    logic [DATA_W-1:0] prod;
    logic [DATA_W-1:0] acc_even;
    logic [DATA_W-1:0] acc_odd;

    always_ff @(posedge clk) begin
        if (kern_we) begin
            kern_mem[kern_wr_addr] <= kern_data;
            if (kern_wr_addr == '0)
                bias <= kern_data;  // first word of the kernel
        end
    end

    // address is held for the whole fetch, so an async read is fine
    assign weight = kern_mem[weight_addr];
    assign prod   = px_data * weight;  // wraps at 16 bits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_even <= '0;
            acc_odd  <= '0;
        end else if (lane_en) begin
            if (acc_init) begin
                acc_even <= bias;
                acc_odd  <= bias;  // stays bias if no odd row follows
            end else if (step) begin
                if (row_sel)
                    acc_odd <= acc_odd + prod;
                else
                    acc_even <= acc_even + prod;
            end
        end
    end

    assign lane_out = lane_en ? {acc_even, acc_odd} : '0;

    // loader and sequencer share the buffer, load and run must not overlap
    a_we_vs_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(kern_we && step)
    ) else $error("kernel write 0x%0h during mac step", kern_wr_addr);

endmodule

// File: verilog/mac_array.sv
`timescale 1ns/1ps

module mac_array import ccm_pkg::*; #(
    parameter int NUM_LANES  = 16,
    parameter int KERN_DEPTH = 4096
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [CHN_W-1:0]                cfg_num_kernel,
    input  logic [NUM_LANES-1:0]            kern_wr_lane,
    input  logic [KADDR_W-1:0]              kern_wr_addr,
    input  logic [DATA_W-1:0]               kern_data,
    input  logic                            kern_vld,
    input  logic                            mac_step,
    input  logic                            px_rd_vld,
    input  logic [DATA_W-1:0]               px_data,
    input  logic [KADDR_W-1:0]              weight_addr,
    input  logic                            row_sel,
    input  logic                            acc_init,
    output logic [NUM_LANES*LANE_OUT_W-1:0] mac_out
);

    logic [NUM_LANES-1:0] lane_en;
    logic                 lane_step;

    // thermometer enable, first cfg_num_kernel lanes on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_en <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++)
                lane_en[i] <= (i < cfg_num_kernel);
        end
    end

    assign lane_step = mac_step & px_rd_vld;  // pixel returned this cycle

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        mac_lane #(
            .KERN_DEPTH (KERN_DEPTH)
        ) u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .lane_en      (lane_en[g]),
            .kern_we      (kern_wr_lane[g] & kern_vld & lane_en[g]),
            .kern_wr_addr (kern_wr_addr),
            .kern_data    (kern_data),
            .step         (lane_step),
            .px_data      (px_data),
            .weight_addr  (weight_addr),
            .row_sel      (row_sel),
            .acc_init     (acc_init),
            .lane_out     (mac_out[(NUM_LANES-1-g)*LANE_OUT_W +: LANE_OUT_W])  // lane 0 on top
        );
    end

endmodule

// File: verilog/ccm_cluster.sv
`timescale 1ns/1ps

module ccm_cluster import ccm_pkg::*; #(
    parameter int NUM_LANES  = 16,
    parameter int KERN_DEPTH = 4096
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            op_start,
    input  logic                            kern_load_start,
    input  logic                            kern_load_work,
    input  logic [DATA_W-1:0]               kern_data,
    input  logic                            kern_vld,
    input  logic                            px_rd_vld,
    input  logic [DATA_W-1:0]               px_data,
    input  logic [ADDR_W-1:0]               row0_addr,
    input  logic                            take_rdy,
    input  logic [DIM_W-1:0]                cfg_width,
    input  logic [DIM_W-1:0]                cfg_height,
    input  logic [CHN_W-1:0]                cfg_num_fmap,
    input  logic [CHN_W-1:0]                cfg_num_kernel,
    input  logic [KSIZE_W-1:0]              cfg_kern_size,
    output logic                            busy,
    output logic                            px_rd_req,
    output logic [ADDR_W-1:0]               px_rd_addr,
    output logic [NUM_LANES*LANE_OUT_W-1:0] mac_out,
    output logic                            take_vld
);

    logic [NUM_LANES-1:0] kern_wr_lane;
    logic [KADDR_W-1:0]   kern_wr_addr;
    logic                 mac_step;
    logic [KADDR_W-1:0]   weight_addr;
    logic                 row_sel;
    logic                 acc_init;

    kernel_loader #(
        .NUM_LANES  (NUM_LANES),
        .KERN_DEPTH (KERN_DEPTH)
    ) u_loader (
        .clk             (clk),
        .rst_n           (rst_n),
        .kern_load_start (kern_load_start),
        .kern_vld        (kern_vld),
        .cfg_num_fmap    (cfg_num_fmap),
        .cfg_kern_size   (cfg_kern_size),
        .kern_wr_lane    (kern_wr_lane),
        .kern_wr_addr    (kern_wr_addr)
    );

    conv_sequencer #(
        .KERN_DEPTH (KERN_DEPTH)
    ) u_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .op_start        (op_start),
        .kern_load_start (kern_load_start),
        .kern_load_work  (kern_load_work),
        .px_rd_vld       (px_rd_vld),
        .take_rdy        (take_rdy),
        .row0_addr       (row0_addr),
        .cfg_width       (cfg_width),
        .cfg_height      (cfg_height),
        .cfg_num_fmap    (cfg_num_fmap),
        .cfg_num_kernel  (cfg_num_kernel),
        .cfg_kern_size   (cfg_kern_size),
        .busy            (busy),
        .px_rd_req       (px_rd_req),
        .px_rd_addr      (px_rd_addr),
        .mac_step        (mac_step),
        .weight_addr     (weight_addr),
        .row_sel         (row_sel),
        .acc_init        (acc_init),
        .take_vld        (take_vld)
    );

    mac_array #(
        .NUM_LANES  (NUM_LANES),
        .KERN_DEPTH (KERN_DEPTH)
    ) u_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg_num_kernel (cfg_num_kernel),
        .kern_wr_lane   (kern_wr_lane),
        .kern_wr_addr   (kern_wr_addr),
        .kern_data      (kern_data),
        .kern_vld       (kern_vld),
        .mac_step       (mac_step),
        .px_rd_vld      (px_rd_vld),
        .px_data        (px_data),
        .weight_addr    (weight_addr),
        .row_sel        (row_sel),
        .acc_init       (acc_init),
        .mac_out        (mac_out)
    );

endmodule

// File: tests/tb_ccm_cluster.sv
`timescale 1ns/1ps

module tb_ccm_cluster import ccm_pkg::*; ();

    localparam int NUM_LANES   = 16;
    localparam int CLK_HALF    = 50;
    localparam int DRIVE_DLY   = 5;
    localparam int NUM_TESTS   = 7;
    localparam int TRACE_WORDS = 64;

    logic                            clk;
    logic                            rst_n;
    logic                            op_start;
    logic                            kern_load_start;
    logic                            kern_load_work;
    logic [DATA_W-1:0]               kern_data;
    logic                            kern_vld;
    logic                            px_rd_vld;
    logic [DATA_W-1:0]               px_data;
    logic [ADDR_W-1:0]               row0_addr;
    logic                            take_rdy;
    logic [DIM_W-1:0]                cfg_width;
    logic [DIM_W-1:0]                cfg_height;
    logic [CHN_W-1:0]                cfg_num_fmap;
    logic [CHN_W-1:0]                cfg_num_kernel;
    logic [KSIZE_W-1:0]              cfg_kern_size;
    logic                            busy;
    logic                            px_rd_req;
    logic [ADDR_W-1:0]               px_rd_addr;
    logic [NUM_LANES*LANE_OUT_W-1:0] mac_out;
    logic                            take_vld;

    logic [31:0]       trace_mem [0:TRACE_WORDS-1];
    logic [ADDR_W-1:0] exp_addr [$];  // pixel reads in loop order
    int                errs [NUM_TESTS];
    int                kern_base;
    int                px_base;
    int                exp_base;
    int                n_kern;
    int                n_kw;
    int                n_pix;
    int                n_reads;
    int                n_hand;
    int                out_rows;
    int                out_cols;
    int                hand_per_col;
    int                wd_cycles;
    int                seed;
    int                fails;
    int                total;

    logic                            run_active;
    logic                            run_done;
    logic                            busy_seen;
    logic                            req_open;
    int                              lat_left;
    logic [ADDR_W-1:0]               req_addr;
    logic                            take_open;
    logic                            rdy_given;
    int                              hand_idx;
    logic [NUM_LANES*LANE_OUT_W-1:0] take_snap;

    ccm_cluster #(
        .NUM_LANES (NUM_LANES)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    function automatic string test_label(input int t);
        case (t)
            0:       return "reset";
            1:       return "kernel_load";
            2:       return "handoff_values";
            3:       return "pixel_address";
            4:       return "odd_row_bias";
            5:       return "unused_lanes";
            default: return "backpressure";
        endcase
    endfunction

    task automatic log_mismatch(input int t, input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("ERROR %s: got 0x%0h expected 0x%0h", what, got, exp);
        errs[t]++;
    endtask

    task automatic log_failure(input int t, input string msg);
        $display("error: %s", msg);
        errs[t]++;
    endtask

    task automatic close_test(input int t);
        $display("test %0d %s: %s, %0d errors", t, test_label(t),
                 (errs[t] == 0) ? "ok" : "not ok", errs[t]);
    endtask

    task automatic load_config();
        int w;
        int h;
        int nf;
        int ks;
        cfg_width      = trace_mem[0][DIM_W-1:0];
        cfg_height     = trace_mem[1][DIM_W-1:0];
        cfg_num_fmap   = trace_mem[2][CHN_W-1:0];
        cfg_num_kernel = trace_mem[3][CHN_W-1:0];
        cfg_kern_size  = trace_mem[4][KSIZE_W-1:0];
        row0_addr      = trace_mem[5][ADDR_W-1:0];
        w = cfg_width;
        h = cfg_height;
        nf = cfg_num_fmap;
        ks = cfg_kern_size;
        n_kern = cfg_num_kernel;
        out_rows = h - ks + 1;
        out_cols = w - ks + 1;
        hand_per_col = (out_rows + 1) / 2;  // last handoff may carry a single row
        n_hand = out_cols * hand_per_col;
        n_kw = n_kern * (1 + nf * ks * ks);
        n_pix = nf * h * w;
        kern_base = 6;
        px_base = kern_base + n_kw;
        exp_base = px_base + n_pix;
        n_reads = out_cols * out_rows * nf * ks * ks;
        for (int c = 0; c < out_cols; c++)
            for (int r = 0; r < out_rows; r++)
                for (int fr = 0; fr < ks; fr++)
                    for (int fc = 0; fc < ks; fc++)
                        for (int ch = 0; ch < nf; ch++)
                            exp_addr.push_back(row0_addr
                                + ADDR_W'(ch * h * w + (r + fr) * w + c + fc));
        wd_cycles = n_reads * 8 + n_hand * 20 + 200;
    endtask

    task automatic load_kernels();
        kern_load_start = 1'b1;
        kern_load_work  = 1'b1;
        @(posedge clk);
        #(DRIVE_DLY);
        kern_load_start = 1'b0;
        if (!busy)
            log_failure(1, "busy did not rise after kern_load_start");
        for (int i = 0; i < n_kw; i++) begin
            kern_vld  = 1'b1;
            kern_data = trace_mem[kern_base + i][DATA_W-1:0];
            @(posedge clk);
            #(DRIVE_DLY);
        end
        kern_vld       = 1'b0;
        kern_data      = '0;
        kern_load_work = 1'b0;
        @(posedge clk);
        #(DRIVE_DLY);
        if (busy)
            log_failure(1, "busy still high after the kernel load ended");
    endtask

    task automatic check_results();
        int                    eb;
        bit                    last_odd;
        logic [LANE_OUT_W-1:0] slice;
        logic [DATA_W-1:0]     even_exp;
        logic [DATA_W-1:0]     odd_exp;
        if (hand_idx >= n_hand) begin
            log_failure(2, "more handoffs than the trace holds");
        end else begin
            last_odd = (out_rows % 2 == 1) && (hand_idx % hand_per_col == hand_per_col - 1);
            for (int l = 0; l < NUM_LANES; l++) begin
                slice = mac_out[(NUM_LANES-1-l)*LANE_OUT_W +: LANE_OUT_W];
                if (l >= n_kern) begin
                    if (slice != '0)
                        log_mismatch(5, $sformatf("mac_out lane %0d", l), slice, 0);
                end else begin
                    eb = exp_base + (hand_idx * n_kern + l) * 2;
                    even_exp = trace_mem[eb][DATA_W-1:0];
                    odd_exp  = trace_mem[eb+1][DATA_W-1:0];
                    if (slice[LANE_OUT_W-1 -: DATA_W] != even_exp)
                        log_mismatch(2, $sformatf("mac_out lane %0d even, handoff %0d",
                                     l, hand_idx), slice[LANE_OUT_W-1 -: DATA_W], even_exp);
                    if (slice[DATA_W-1:0] != odd_exp)
                        log_mismatch(last_odd ? 4 : 2, $sformatf("mac_out lane %0d odd, handoff %0d",
                                     l, hand_idx), slice[DATA_W-1:0], odd_exp);
                end
            end
        end
    endtask

    task automatic serve_cycle();
        int idx;
        px_rd_vld = 1'b0;
        take_rdy  = 1'b0;
        if (busy)
            busy_seen = 1'b1;
        if (px_rd_req) begin  // pixel memory model
            if (!req_open) begin
                if (exp_addr.size() == 0)
                    log_failure(3, "pixel request beyond the expected read count");
                else if (px_rd_addr != exp_addr[0])
                    log_mismatch(3, "px_rd_addr", px_rd_addr, exp_addr[0]);
                if (exp_addr.size() != 0)
                    exp_addr.pop_front();
                req_addr = px_rd_addr;
                req_open = 1'b1;
                lat_left = $urandom_range(1, 4);
            end else if (px_rd_addr != req_addr) begin
                log_mismatch(3, "px_rd_addr while held", px_rd_addr, req_addr);
            end
            lat_left--;
            if (lat_left == 0) begin
                idx = int'(px_rd_addr) - int'(row0_addr);
                if (idx < 0 || idx >= n_pix) begin
                    log_failure(3, "pixel address outside the image");
                    px_data = '0;
                end else begin
                    px_data = trace_mem[px_base + idx][DATA_W-1:0];
                end
                px_rd_vld = 1'b1;
                req_open  = 1'b0;
            end
        end
        if (take_vld) begin
            if (px_rd_req)
                log_failure(6, "pixel request during encoder handoff");
            if (rdy_given)
                log_failure(6, "take_vld still high after the handoff completed");
            if (!take_open) begin
                check_results();
                take_snap = mac_out;
                take_open = 1'b1;
            end else if (mac_out != take_snap) begin
                log_failure(6, "mac_out changed while the handoff was stalled");
            end
            take_rdy  = ($urandom_range(0, 2) == 0);  // stall about two cycles in three
            rdy_given = take_rdy;
        end else if (take_open) begin
            if (!rdy_given)
                log_failure(6, "take_vld fell without take_rdy");
            take_open = 1'b0;
            rdy_given = 1'b0;
            hand_idx++;
        end
        if (busy_seen && !busy) begin
            if (take_open || hand_idx != n_hand)
                log_failure(6, "busy fell before the last handoff");
            run_active = 1'b0;
            run_done   = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        #(DRIVE_DLY);
        if (run_active)
            serve_cycle();
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", wd_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed = 32'hb46e_0330;
        void'($urandom(seed));
        rst_n           = 1'b0;
        op_start        = 1'b0;
        kern_load_start = 1'b0;
        kern_load_work  = 1'b0;
        kern_data       = '0;
        kern_vld        = 1'b0;
        px_rd_vld       = 1'b0;
        px_data         = '0;
        take_rdy        = 1'b0;
        row0_addr       = '0;
        cfg_width       = '0;
        cfg_height      = '0;
        cfg_num_fmap    = '0;
        cfg_num_kernel  = '0;
        cfg_kern_size   = '0;
        run_active      = 1'b0;
        run_done        = 1'b0;
        busy_seen       = 1'b0;
        req_open        = 1'b0;
        lat_left        = 0;
        req_addr        = '0;
        take_open       = 1'b0;
        rdy_given       = 1'b0;
        hand_idx        = 0;
        take_snap       = '0;
        for (int i = 0; i < NUM_TESTS; i++)
            errs[i] = 0;
        $readmemh("tests/ccm_trace.txt", trace_mem);
        load_config();
        repeat (4) @(posedge clk);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        @(posedge clk);
        #(DRIVE_DLY);
        if (busy !== 1'b0)
            log_mismatch(0, "busy", busy, 0);
        if (px_rd_req !== 1'b0)
            log_mismatch(0, "px_rd_req", px_rd_req, 0);
        if (take_vld !== 1'b0)
            log_mismatch(0, "take_vld", take_vld, 0);
        close_test(0);
        load_kernels();
        close_test(1);
        op_start   = 1'b1;
        run_active = 1'b1;
        @(posedge clk);
        #(DRIVE_DLY);
        op_start = 1'b0;
        if (!busy)
            log_failure(2, "busy did not rise after op_start");
        wait (run_done);
        if (exp_addr.size() != 0)
            log_failure(3, $sformatf("%0d pixel reads were never requested", exp_addr.size()));
        for (int t = 2; t < NUM_TESTS; t++)
            close_test(t);
        fails = 0;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += errs[t];
            if (errs[t] != 0)
                fails++;
        end
        $display("%0d tests, %0d failing, %0d errors", NUM_TESTS, fails, total);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: tests/ccm_trace.txt
// ccm_cluster trace, hex words read in order
// config: cfg_width cfg_height cfg_num_fmap cfg_num_kernel cfg_kern_size row0_addr
0003 0004 0002 0002 0002 00100
// kernels, per lane: bias, then weights by channel, filter row, filter column
// lane 0
0010
0001 0002 0003 0000
0001 0001 0000 0002
// lane 1, negative bias so the sums wrap
fff0
0002 0000 0001 0001
0003 0000 0001 0002
// pixel image channel 0, one image row per line
0001 0002 0003
0004 0005 0006
0007 0008 0009
000a 000b 000c
// channel 1
0002 0000 0001
0003 0001 0002
0000 0002 0004
0001 0003 0005
// expected per handoff: lane 0 even, lane 0 odd, lane 1 even, lane 1 odd
// column 0, rows 0 and 1
0025 003b 0006 0014
// column 0, row 2 alone, odd half keeps the bias
004d 0010 001a fff0
// column 1, rows 0 and 1
002c 0044 0004 0018
// column 1, row 2 alone
005b 0010 002a fff0

// File: sources.f
verilog/ccm_pkg.sv
verilog/kernel_loader.sv
verilog/conv_sequencer.sv
verilog/mac_lane.sv
verilog/mac_array.sv
verilog/ccm_cluster.sv
tests/tb_ccm_cluster.sv
